// ==== vlog.f ====
verilog/rename_pkg.sv
verilog/free_list.sv
verilog/rat.sv
verilog/rename_stage.sv
verilog/rename_unit.sv
testbench/rename_assertions.sv
testbench/tb_rename.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps -f vlog.f \
    --top-module tb_rename -o tb_rename || { echo "build failed"; exit 1; }
out=$(./obj_dir/tb_rename +verilator+error+limit+1000)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qF "Done: no errors" && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== testbench/tb_rename.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_rename;
    import rename_pkg::*;

    localparam int WAIT_LIMIT = 50;   // stall cycles before giving up

    logic      clk;
    logic      rstn;
    logic      in_valid;
    dec_inst_t inst;
    logic      retire_valid;
    preg_t     retire_tag;
    logic      out_valid;
    ren_uop_t  uop;
    logic      stall;

    preg_t            map [NUM_AREG];   // model alias table
    preg_t            free_q [$];       // model free list in hand-out order
    preg_t            retirable [$];    // old mappings not yet retired
    logic [ROB_W-1:0] rob;              // next expected rob_num
    int unsigned      seed;
    int               errors;
    int               errors_at_start;
    int               tests_run;
    logic             timed_out;
    dec_inst_t        ri;

    rename_unit dut (.*);

    bind rename_unit rename_assertions u_rename_assertions (.*);

    always #2 clk = ~clk;   // 4 ns period

    function automatic int unsigned next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;   // lcg step
        return seed >> 8;
    endfunction

    function automatic logic [6:0] random_opcode();
        case (next_random() % 5)
            0:       return 7'b0110011;   // alu reg-reg
            1:       return 7'b0010011;   // alu immediate
            2:       return 7'b0000011;   // load
            3:       return OP_STORE;
            default: return OP_BRANCH;
        endcase
    endfunction

    function automatic dec_inst_t random_inst(input logic [6:0] op, input logic need_dst);
        dec_inst_t i;
        i.opcode  = op;
        i.sr1     = areg_t'(next_random());
        i.sr2     = areg_t'(next_random());
        i.dr      = areg_t'(next_random());
        i.has_imm = 1'(next_random());
        i.imm     = next_random() ^ (next_random() << 12);
        if (need_dst && i.dr == '0) begin
            i.dr = 5'd1;   // x0 never allocates
        end
        return i;
    endfunction

    // instruction takes a new physical register
    function automatic logic needs_tag(input dec_inst_t i);
        return !(i.opcode inside {OP_STORE, OP_BRANCH, OP_NOP}) && (i.dr != '0);
    endfunction

    task automatic compare_field(input string name, input logic [72:0] got,
                                 input logic [72:0] exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got %0h expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    // hand back the oldest displaced mapping
    task automatic retire_one();
        preg_t tag;
        if (retirable.size() != 0) begin
            tag = retirable.pop_front();
            @(posedge clk);
            retire_valid <= 1'b1;
            retire_tag   <= tag;
            @(posedge clk);
            retire_valid <= 1'b0;
            free_q.push_back(tag);   // allocatable from the next edge
        end
    endtask

    task automatic send(input dec_inst_t i);
        ren_uop_t exp;
        logic     wd;
        logic     exp_stall;
        int       waited;
        if (!timed_out) begin
            wd = needs_tag(i);
            @(posedge clk);
            in_valid <= 1'b1;
            inst     <= i;
            waited = 0;
            do begin
                @(negedge clk);
                exp_stall = wd && (free_q.size() == 0);   // no retire bypass
                compare_field("stall", 73'(stall), 73'(exp_stall));
                waited++;
            end while (stall && waited < WAIT_LIMIT);
            if (stall) begin
                $display("instruction still stalled after %0d cycles", WAIT_LIMIT);
                timed_out = 1'b1;
            end else begin
                exp.rob_num   = rob;
                exp.src1_p    = map[i.sr1];   // mapping before this instruction
                exp.src2_p    = map[i.sr2];
                exp.dst_valid = wd;
                exp.has_imm   = i.has_imm;
                exp.imm       = i.imm;
                exp.opcode    = i.opcode;
                if (wd) begin
                    exp.dst_p     = free_q.pop_front();
                    exp.old_dst_p = map[i.dr];
                    map[i.dr]     = exp.dst_p;
                    retirable.push_back(exp.old_dst_p);
                end else begin
                    exp.dst_p     = map[i.dr];
                    exp.old_dst_p = '0;
                end
                rob = rob + 1'b1;   // wraps at 32
                @(posedge clk);     // acceptance edge
                in_valid <= 1'b0;
                @(negedge clk);
                compare_field("out_valid", 73'(out_valid), 73'(1'b1));
                compare_field("uop", uop, exp);
            end
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        $display("test %0d (%s): %0d errors", tests_run, name, errors - errors_at_start);
        errors_at_start = errors;
    endtask

    initial begin
        clk             = 1'b0;
        rstn            = 1'b0;
        in_valid        = 1'b0;
        inst            = '0;
        retire_valid    = 1'b0;
        retire_tag      = '0;
        rob             = '0;
        seed            = 34621;
        errors          = 0;
        errors_at_start = 0;
        tests_run       = 0;
        timed_out       = 1'b0;
        for (int a = 0; a < NUM_AREG; a++) begin
            map[a] = preg_t'(a);   // identity after reset
        end
        for (int t = NUM_AREG; t < NUM_PREG; t++) begin
            free_q.push_back(preg_t'(t));
        end
        repeat (10) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        compare_field("out_valid", 73'(out_valid), 73'(1'b0));
        compare_field("stall", 73'(stall), 73'(1'b0));
        for (int n = 0; n < NUM_FREE; n++) begin
            send(random_inst(7'b0110011, 1'b1));   // drains 32..63 in order
        end
        finish_test("reset and first allocation");

        fork   // free list stays empty until the retirement releases the held op
            send(random_inst(7'b0110011, 1'b1));
            begin
                repeat (4) @(posedge clk);
                retire_one();
            end
        join
        finish_test("exhaustion and stall");

        repeat (3) retire_one();
        repeat (3) send(random_inst(7'b0110011, 1'b1));
        retire_one();
        fork   // pop and push on the same edge
            send(random_inst(7'b0110011, 1'b1));
            retire_one();
        join
        send(random_inst(7'b0110011, 1'b1));
        finish_test("retire ordering");

        for (int n = 0; n < 40; n++) begin
            ri = random_inst(random_opcode(), 1'b0);
            if (n % 4 == 0) begin
                ri.sr1 = ri.dr;   // reads its own destination
            end
            if (needs_tag(ri) && free_q.size() == 0) begin
                retire_one();   // ops without a destination pass an empty free list
            end
            send(ri);
        end
        finish_test("lookup and old mapping");

        if (free_q.size() == 0) begin
            retire_one();
        end
        send(random_inst(OP_STORE, 1'b0));
        send(random_inst(OP_BRANCH, 1'b0));
        send(random_inst(OP_NOP, 1'b0));
        ri    = random_inst(7'b0110011, 1'b0);
        ri.dr = '0;
        send(ri);
        send(random_inst(7'b0110011, 1'b1));   // head tag still unused
        finish_test("no allocation");

        for (int n = 0; n < 4; n++) begin
            if (free_q.size() == 0) begin
                retire_one();
            end
            ri         = random_inst(7'b0010011, 1'b1);
            ri.has_imm = 1'b1;
            if (n == 0) begin
                ri.imm = 32'hffff_ffff;
            end
            send(ri);
        end
        finish_test("immediate pass-through");

        $display("%0d tests, %0d check errors, %0d assertion failures",
                 tests_run, errors, dut.u_rename_assertions.fail_count);
        if (errors == 0 && !timed_out && dut.u_rename_assertions.fail_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/rename_assertions.sv ====
`timescale 1ns/100ps
`default_nettype none

module rename_assertions (
    input wire                  clk,
    input wire                  rstn,
    input wire                  in_valid,
    input wire                  retire_valid,
    input wire                  out_valid,
    input rename_pkg::ren_uop_t uop,
    input wire                  stall
);
    import rename_pkg::*;

    int unsigned fail_count = 0;   // failed assertions so far
    int          free_cnt;         // pops enter one cycle late, seen on uop
    int          free_now;         // free tags right now
    logic        accept;

    assign accept   = in_valid && !stall;
    assign free_now = free_cnt - ((out_valid && uop.dst_valid) ? 1 : 0);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            free_cnt <= NUM_FREE;                           // tags 32..63
        end else begin
            free_cnt <= free_now + (retire_valid ? 1 : 0);
        end
    end

    // out_valid is exactly the acceptance of the cycle before
    a_out_follows_accept: assert property (@(posedge clk) disable iff (!rstn)
        out_valid == $past(accept))
        else begin
            $error("out_valid does not follow acceptance by one cycle");
            fail_count++;
        end

    // quiet outputs coming out of reset
    a_quiet_after_reset: assert property (@(posedge clk)
        !rstn |=> (!stall && !out_valid))
        else begin
            $error("stall or out_valid high right after reset");
            fail_count++;
        end

    // retirement can only hand back a tag that is in use
    a_no_push_when_full: assert property (@(posedge clk) disable iff (!rstn)
        retire_valid |-> (free_now < NUM_FREE))
        else begin
            $error("retirement while all free-list entries are free");
            fail_count++;
        end

endmodule

`default_nettype wire

// ==== verilog/rename_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module rename_unit (
    input  wire                   clk,
    input  wire                   rstn,
    input  wire                   in_valid,
    input  rename_pkg::dec_inst_t inst,
    input  wire                   retire_valid,
    input  rename_pkg::preg_t     retire_tag,   // old_dst_p of the retiring op
    output logic                  out_valid,
    output rename_pkg::ren_uop_t  uop,
    output logic                  stall
);
    import rename_pkg::*;

    logic  alloc;
    preg_t free_tag;
    logic  fl_empty;

    areg_t rat_sr1;
    areg_t rat_sr2;
    areg_t rat_dr;
    preg_t src1_p;
    preg_t src2_p;
    preg_t old_p;

    logic  rat_we;
    areg_t rat_wr_idx;
    preg_t rat_wr_p;

    free_list u_free_list (
        .clk           (clk),
        .rstn          (rstn),
        .alloc         (alloc),
        .free_tag      (free_tag),
        .empty         (fl_empty),
        .release_valid (retire_valid),   // retirement pushes directly
        .release_tag   (retire_tag)
    );

    rat u_rat (
        .clk     (clk),
        .rstn    (rstn),
        .rd1_idx (rat_sr1),
        .rd2_idx (rat_sr2),
        .rd3_idx (rat_dr),
        .rd1_p   (src1_p),
        .rd2_p   (src2_p),
        .rd3_p   (old_p),
        .wr_en   (rat_we),
        .wr_idx  (rat_wr_idx),
        .wr_p    (rat_wr_p)
    );

    rename_stage u_rename_stage (
        .clk        (clk),
        .rstn       (rstn),
        .in_valid   (in_valid),
        .inst       (inst),
        .stall      (stall),
        .out_valid  (out_valid),
        .uop        (uop),
        .alloc      (alloc),
        .free_tag   (free_tag),
        .fl_empty   (fl_empty),
        .rat_sr1    (rat_sr1),
        .rat_sr2    (rat_sr2),
        .rat_dr     (rat_dr),
        .src1_p     (src1_p),
        .src2_p     (src2_p),
        .old_p      (old_p),
        .rat_we     (rat_we),
        .rat_wr_idx (rat_wr_idx),
        .rat_wr_p   (rat_wr_p)
    );

endmodule

`default_nettype wire

// ==== verilog/rename_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module rename_stage (
    input  wire                   clk,
    input  wire                   rstn,
    // from decode
    input  wire                   in_valid,
    input  rename_pkg::dec_inst_t inst,
    output logic                  stall,
    // to dispatch
    output logic                  out_valid,
    output rename_pkg::ren_uop_t  uop,
    // free list
    output logic                  alloc,
    input  rename_pkg::preg_t     free_tag,
    input  wire                   fl_empty,
    // alias table lookups
    output rename_pkg::areg_t     rat_sr1,
    output rename_pkg::areg_t     rat_sr2,
    output rename_pkg::areg_t     rat_dr,
    input  rename_pkg::preg_t     src1_p,
    input  rename_pkg::preg_t     src2_p,
    input  rename_pkg::preg_t     old_p,
    // alias table update
    output logic                  rat_we,
    output rename_pkg::areg_t     rat_wr_idx,
    output rename_pkg::preg_t     rat_wr_p
);
    import rename_pkg::*;

    logic             need_dst;   // instruction writes a real destination
    logic             accept;
    logic [ROB_W-1:0] rob_cnt_q;  // next reorder buffer number

    assign need_dst = writes_dest(inst);

    // retirement in this cycle is not seen, empty means wait
    assign stall  = in_valid && need_dst && fl_empty;
    assign accept = in_valid && !stall;

    // lookups run every cycle straight off the instruction
    assign rat_sr1 = inst.sr1;
    assign rat_sr2 = inst.sr2;
    assign rat_dr  = inst.dr;

    // pop and table write share the acceptance edge
    assign alloc      = accept && need_dst;
    assign rat_we     = alloc;
    assign rat_wr_idx = inst.dr;
    assign rat_wr_p   = free_tag;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            out_valid <= 1'b0;
            rob_cnt_q <= '0;
        end else begin
            out_valid <= accept;                 // one pulse per instruction
            if (accept) begin
                rob_cnt_q <= rob_cnt_q + 1'b1;   // wraps at 32
            end
        end
    end

    // micro-op payload, only loaded on acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            uop.rob_num   <= rob_cnt_q;
            uop.src1_p    <= src1_p;
            uop.src2_p    <= src2_p;
            uop.dst_valid <= need_dst;
            if (need_dst) begin
                uop.dst_p     <= free_tag;
                uop.old_dst_p <= old_p;     // returned to the free list on retire
            end else begin
                uop.dst_p     <= old_p;     // current mapping, nothing allocated
                uop.old_dst_p <= '0;
            end
            uop.has_imm   <= inst.has_imm;
            uop.imm       <= inst.imm;
            uop.opcode    <= inst.opcode;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rat.sv ====
`timescale 1ns/100ps
`default_nettype none

module rat (
    input  wire                clk,
    input  wire                rstn,
    input  rename_pkg::areg_t  rd1_idx,   // source 1
    input  rename_pkg::areg_t  rd2_idx,   // source 2
    input  rename_pkg::areg_t  rd3_idx,   // destination, old mapping
    output rename_pkg::preg_t  rd1_p,
    output rename_pkg::preg_t  rd2_p,
    output rename_pkg::preg_t  rd3_p,
    input  wire                wr_en,
    input  rename_pkg::areg_t  wr_idx,
    input  rename_pkg::preg_t  wr_p
);
    import rename_pkg::*;

    preg_t map_q [NUM_AREG];   // architectural -> physical

    // reads see the table before this edge's write
    assign rd1_p = map_q[rd1_idx];
    assign rd2_p = map_q[rd2_idx];
    assign rd3_p = map_q[rd3_idx];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < NUM_AREG; i++) begin
                map_q[i] <= preg_t'(i);   // identity mapping
            end
        end else if (wr_en) begin
            map_q[wr_idx] <= wr_p;        // x0 never arrives here
        end
    end

endmodule

`default_nettype wire

// ==== verilog/free_list.sv ====
`timescale 1ns/100ps
`default_nettype none

module free_list (
    input  wire                clk,
    input  wire                rstn,
    input  wire                alloc,          // pop on this edge
    output rename_pkg::preg_t  free_tag,       // head of the queue
    output logic               empty,
    input  wire                release_valid,  // push on this edge
    input  rename_pkg::preg_t  release_tag
);
    import rename_pkg::*;

    preg_t               fifo_q [NUM_FREE];   // circular storage of free tags
    logic [FL_PTR_W-1:0] head_q;              // next tag to hand out
    logic [FL_PTR_W-1:0] tail_q;              // next slot to fill
    logic [FL_CNT_W-1:0] count_q;             // tags currently free

    logic pop;
    logic push;

    assign pop  = alloc;          // rename never pops when empty
    assign push = release_valid;

    assign free_tag = fifo_q[head_q];
    assign empty    = (count_q == '0);

    // storage, filled with tags 32..63 in order at reset
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < NUM_FREE; i++) begin
                fifo_q[i] <= preg_t'(NUM_AREG + i);
            end
        end else if (push) begin
            fifo_q[tail_q] <= release_tag;
        end
    end

    // pointers wrap naturally, NUM_FREE is a power of two
    always_ff @(posedge clk) begin
        if (!rstn) begin
            head_q <= '0;
            tail_q <= '0;          // queue starts full, tail meets head
        end else begin
            if (pop) begin
                head_q <= head_q + 1'b1;
            end
            if (push) begin
                tail_q <= tail_q + 1'b1;
            end
        end
    end

    // occupancy, a simultaneous pop and push cancel out
    always_ff @(posedge clk) begin
        if (!rstn) begin
            count_q <= FL_CNT_W'(NUM_FREE);
        end else begin
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rename_pkg.sv ====
`default_nettype none

package rename_pkg;

    // register file sizes
    localparam int AREG_W   = 5;                  // architectural index width
    localparam int PREG_W   = 6;                  // physical tag width
    localparam int NUM_AREG = 32;
    localparam int NUM_PREG = 64;
    localparam int NUM_FREE = NUM_PREG - NUM_AREG; // tags not mapped at reset
    localparam int ROB_W    = 5;                  // reorder buffer number width

    // free list pointer and occupancy widths
    localparam int FL_PTR_W = $clog2(NUM_FREE);
    localparam int FL_CNT_W = $clog2(NUM_FREE) + 1; // count runs 0..NUM_FREE

    // opcodes without a destination write
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_NOP    = 7'b0000000;

    typedef logic [AREG_W-1:0] areg_t;
    typedef logic [PREG_W-1:0] preg_t;

    // decoded instruction as handed over by decode
    typedef struct packed {
        logic [6:0]  opcode;
        areg_t       sr1;
        areg_t       sr2;
        areg_t       dr;
        logic        has_imm;
        logic [31:0] imm;
    } dec_inst_t;

    // renamed micro-op sent towards dispatch
    typedef struct packed {
        logic [ROB_W-1:0] rob_num;
        preg_t            src1_p;
        preg_t            src2_p;
        logic             dst_valid;   // dst_p is freshly allocated
        preg_t            dst_p;
        preg_t            old_dst_p;   // freed again at retirement
        logic             has_imm;
        logic [31:0]      imm;
        logic [6:0]       opcode;
    } ren_uop_t;

    // true when the instruction needs a new physical register
    function automatic logic writes_dest(input dec_inst_t i);
        logic no_dst_op;
        no_dst_op = (i.opcode == OP_STORE) || (i.opcode == OP_BRANCH) ||
                    (i.opcode == OP_NOP);
        return !no_dst_op && (i.dr != '0); // x0 is hardwired, never renamed
    endfunction

endpackage

`default_nettype wire
